// File: Makefile
# Verilator build and run for the gamepad and audio block

VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = tb_spacewar
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/melody_table.sv
`timescale 1ns/10ps

module melody_table (
  input  logic                clk,
  input  logic                rst_n,
  input  spacewar_pkg::pos_t  position,
  output spacewar_pkg::note_e note
);

  import spacewar_pkg::*;

  note_e note_next;

  // Melody lookup, grouped by note
  always_comb begin
    case (position)
      // Highest pitch
      7'd70, 7'd71, 7'd86, 7'd102, 7'd103:
        note_next = NOTE_0;
      7'd69, 7'd76, 7'd77, 7'd85, 7'd101, 7'd108, 7'd109, 7'd126, 7'd127:
        note_next = NOTE_1;
      7'd6, 7'd7, 7'd22, 7'd38, 7'd39, 7'd68, 7'd75, 7'd78,
      7'd79, 7'd84, 7'd100, 7'd107, 7'd110, 7'd111, 7'd125:
        note_next = NOTE_2;
      7'd5, 7'd12, 7'd13, 7'd21, 7'd37, 7'd44, 7'd45, 7'd62,
      7'd63, 7'd74, 7'd80, 7'd87, 7'd90, 7'd96, 7'd106, 7'd112,
      7'd118, 7'd122, 7'd124:
        note_next = NOTE_3;
      // Most common note of the tune
      7'd4, 7'd11, 7'd14, 7'd15, 7'd20, 7'd36, 7'd43, 7'd46,
      7'd47, 7'd61, 7'd65, 7'd66, 7'd67, 7'd72, 7'd73, 7'd81,
      7'd82, 7'd83, 7'd88, 7'd89, 7'd91, 7'd92, 7'd93, 7'd94,
      7'd95, 7'd97, 7'd98, 7'd99, 7'd104, 7'd105, 7'd113, 7'd116,
      7'd117, 7'd119, 7'd120, 7'd121, 7'd123:
        note_next = NOTE_4;
      7'd0, 7'd10, 7'd16, 7'd23, 7'd26, 7'd32, 7'd42, 7'd48,
      7'd53, 7'd58, 7'd60, 7'd64, 7'd114, 7'd115:
        note_next = NOTE_5;
      7'd1, 7'd2, 7'd3, 7'd8, 7'd9, 7'd17, 7'd18, 7'd19,
      7'd24, 7'd25, 7'd27, 7'd28, 7'd29, 7'd30, 7'd31, 7'd33,
      7'd34, 7'd35, 7'd40, 7'd41, 7'd49, 7'd52, 7'd54, 7'd55,
      7'd56, 7'd57, 7'd59:
        note_next = NOTE_6;
      // Lowest pitch, only two steps
      7'd50, 7'd51:
        note_next = NOTE_7;
      default:
        note_next = NOTE_REST;
    endcase
  end

  // One cycle behind position
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      note <= NOTE_0;
    end else begin
      note <= note_next;
    end
  end

endmodule

// File: hdl/note_timer.sv
`timescale 1ns/10ps

module note_timer #(
  parameter int unsigned NOTE_TICKS = spacewar_pkg::NOTE_TICKS_DEFAULT
) (
  input  logic               clk,
  input  logic               rst_n,
  output spacewar_pkg::pos_t position
);

  import spacewar_pkg::*;

  // Last tick value of a melody step
  localparam logic [NOTE_TICK_BITS-1:0] TICK_LAST = NOTE_TICK_BITS'(NOTE_TICKS);

  logic [NOTE_TICK_BITS-1:0] tick_count;
  logic                      step_done;

  assign step_done = (tick_count == TICK_LAST);

  // Tick counter runs from reset release
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tick_count <= '0;
    end else if (step_done) begin
      tick_count <= '0;
    end else begin
      tick_count <= tick_count + 1'b1;
    end
  end

  // Melody position wraps 127 to 0 on its own
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      position <= '0;
    end else if (step_done) begin
      position <= position + 1'b1;
    end
  end

  // Counter must stay within one step
  a_tick_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    tick_count <= TICK_LAST
  ) else $error("note tick counter above NOTE_TICKS");

endmodule

// File: hdl/pad_receiver.sv
`timescale 1ns/10ps

module pad_receiver (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pmod_data,
  input  logic                       pmod_clk,
  input  logic                       pmod_latch,
  output spacewar_pkg::pad_buttons_t buttons,
  output logic                       pad_present
);

  import spacewar_pkg::*;

  // Two-stage synchronisers, bit 1 is the stable stage
  logic [1:0] data_sync;
  logic [1:0] clk_sync;
  logic [1:0] latch_sync;

  // Previous stable level for edge detect
  logic clk_prev;
  logic latch_prev;

  logic clk_rise;
  logic latch_rise;

  // Serial shift and captured frame
  pad_frame_t shift_reg;
  pad_frame_t frame;

  logic frame_empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_sync  <= 2'b00;
      clk_sync   <= 2'b00;
      latch_sync <= 2'b00;
      clk_prev   <= 1'b0;
      latch_prev <= 1'b0;
    end else begin
      data_sync  <= {data_sync[0], pmod_data};
      clk_sync   <= {clk_sync[0], pmod_clk};
      latch_sync <= {latch_sync[0], pmod_latch};
      clk_prev   <= clk_sync[1];
      latch_prev <= latch_sync[1];
    end
  end

  assign clk_rise   = clk_sync[1] & ~clk_prev;
  assign latch_rise = latch_sync[1] & ~latch_prev;

  // All ones after reset so no pad is reported
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_reg <= '1;
      frame     <= '1;
    end else begin
      // New bit enters at the bottom and climbs toward b
      if (clk_rise) begin
        shift_reg <= {shift_reg[PAD_BITS-2:0], data_sync[1]};
      end
      // Latch edge captures whatever was shifted so far
      if (latch_rise) begin
        frame <= shift_reg;
      end
    end
  end

  // Idle data line reads high, so all ones means nothing attached
  assign frame_empty = (frame == '1);
  assign pad_present = ~frame_empty;
  assign buttons     = frame_empty ? '0 : pad_buttons_t'(frame);

  // Presence implies a real frame passed straight to the buttons
  a_present_frame : assert property (
    @(posedge clk) disable iff (!rst_n)
    pad_present |-> (frame != '1) && (buttons == frame)
  ) else $error("pad_present high with empty or mismatched frame");

endmodule

// File: hdl/spacewar_audio_top.sv
`timescale 1ns/10ps

module spacewar_audio_top #(
  parameter int unsigned NOTE_TICKS = spacewar_pkg::NOTE_TICKS_DEFAULT,
  parameter int unsigned TONE_SHIFT = 0
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pmod_data,
  input  logic                       pmod_clk,
  input  logic                       pmod_latch,
  output spacewar_pkg::pad_buttons_t buttons,
  output logic                       pad_present,
  output logic                       audio
);

  import spacewar_pkg::*;

  // Audio chain links
  pos_t  position;
  note_e note;

  // Gamepad side
  pad_receiver pad_receiver_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .pmod_data   (pmod_data),
    .pmod_clk    (pmod_clk),
    .pmod_latch  (pmod_latch),
    .buttons     (buttons),
    .pad_present (pad_present)
  );

  // Melody step clock
  note_timer #(
    .NOTE_TICKS (NOTE_TICKS)
  ) note_timer_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .position (position)
  );

  // Step to note
  melody_table melody_table_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .position (position),
    .note     (note)
  );

  // Note to square wave
  tone_pwm #(
    .TONE_SHIFT (TONE_SHIFT)
  ) tone_pwm_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .note  (note),
    .audio (audio)
  );

endmodule

// File: hdl/spacewar_pkg.sv
package spacewar_pkg;

  // Note codes from highest pitch down to lowest
  // Rest sits just above the eight pitches
  typedef enum logic [3:0] {
    NOTE_0    = 4'd0,
    NOTE_1    = 4'd1,
    NOTE_2    = 4'd2,
    NOTE_3    = 4'd3,
    NOTE_4    = 4'd4,
    NOTE_5    = 4'd5,
    NOTE_6    = 4'd6,
    NOTE_7    = 4'd7,
    NOTE_REST = 4'd8
  } note_e;

  // Gamepad serial frame
  localparam int PAD_BITS = 12;

  typedef logic [PAD_BITS-1:0] pad_frame_t;

  // Button bits in frame order
  // First bit on the wire lands in b
  typedef struct packed {
    logic b;
    logic y;
    logic select;
    logic start;
    logic up;
    logic down;
    logic left;
    logic right;
    logic a;
    logic x;
    logic l;
    logic r;
  } pad_buttons_t;

  // Melody has 128 steps
  localparam int POS_BITS = 7;

  typedef logic [POS_BITS-1:0] pos_t;

  // Tone period counter
  localparam int TONE_BITS = 18;

  typedef logic [TONE_BITS-1:0] tone_t;

  // Half-period limits per note
  // Indexed by note code, rest gives a zero limit
  localparam tone_t TONE_LIMIT [0:8] = '{
    18'd41667,
    18'd43748,
    18'd45455,
    18'd50000,
    18'd55556,
    18'd62500,
    18'd71429,
    18'd83333,
    18'd0
  };

  // Clock cycles per melody step minus one
  localparam int unsigned NOTE_TICKS_DEFAULT = 3375000;

  // Wide enough for the default step length
  localparam int NOTE_TICK_BITS = 22;

endpackage

// File: hdl/tone_pwm.sv
`timescale 1ns/10ps

module tone_pwm #(
  parameter int unsigned TONE_SHIFT = 0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  spacewar_pkg::note_e note,
  output logic                audio
);

  import spacewar_pkg::*;

  tone_t limit_next;
  tone_t limit;
  tone_t count;
  logic  restart;

  // Table lookup scaled for the clock rate
  always_comb begin
    if (note > NOTE_REST) begin
      // Codes past rest are silent too
      limit_next = '0;
    end else begin
      limit_next = TONE_LIMIT[note] >> TONE_SHIFT;
    end
  end

  // Limit lags the note by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      limit <= '0;
    end else begin
      limit <= limit_next;
    end
  end

  // At or above so a shorter new limit takes effect at once
  assign restart = (count >= limit);

  // Half period is limit plus one cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (restart) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Square wave flips on every restart
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      audio <= 1'b0;
    end else if (restart) begin
      audio <= ~audio;
    end
  end

  // Restart always lands the counter on zero
  a_restart_zero : assert property (
    @(posedge clk) disable iff (!rst_n)
    restart |=> (count == '0)
  ) else $error("tone counter not zero after restart");

endmodule

// File: list.f
hdl/spacewar_pkg.sv
hdl/pad_receiver.sv
hdl/note_timer.sv
hdl/melody_table.sv
hdl/tone_pwm.sv
hdl/spacewar_audio_top.sv
verif/tb_spacewar.sv

// File: verif/spacewar_tests.txt
# pad <frame hex> <expected buttons hex> <expected present 0/1> <extra clock pulses before frame>
# mel <melody position> <expected note code, 0 highest pitch, 8 rest>
pad 800 800 1 0
pad 001 001 1 0
pad a5c a5c 1 0
pad 3e1 3e1 1 0
pad fff 000 0 0
pad 5a3 5a3 1 0
pad 0f0 0f0 1 3
pad 123 123 1 5
mel 4 4
mel 5 3
mel 6 2
mel 50 7
mel 58 5
mel 59 6
mel 69 1
mel 70 0
mel 86 0
mel 127 1

// File: verif/tb_spacewar.sv
`timescale 1ns/10ps

module tb_spacewar;

  import spacewar_pkg::*;

  localparam int unsigned NOTE_TICKS = 3999;
  localparam int unsigned TONE_SHIFT = 8;
  // Clocks per Pmod level
  localparam int HOLD = 4;
  // Frame shows on the third edge after the one that samples the latch
  localparam int LATCH_TIMEOUT = 4;
  localparam int TOGGLE_TIMEOUT = 2000;
  localparam int WINDOW_TIMEOUT = 600000;
  // Margin into a melody step before measuring
  localparam int SETTLE = 100;

  // Reference half-period limits from highest pitch down, rest last
  localparam tone_t TONE_REF [0:8] = '{
    18'd41667, 18'd43748, 18'd45455, 18'd50000, 18'd55556,
    18'd62500, 18'd71429, 18'd83333, 18'd0
  };

  logic         clk;
  logic         rst_n;
  logic         pmod_data;
  logic         pmod_clk;
  logic         pmod_latch;
  pad_buttons_t buttons;
  logic         pad_present;
  logic         audio;
  // Cycles since reset release
  int           cyc;

  spacewar_audio_top #(
    .NOTE_TICKS (NOTE_TICKS),
    .TONE_SHIFT (TONE_SHIFT)
  ) spacewar_audio_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .pmod_data   (pmod_data),
    .pmod_clk    (pmod_clk),
    .pmod_latch  (pmod_latch),
    .buttons     (buttons),
    .pad_present (pad_present),
    .audio       (audio)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_buttons(input pad_buttons_t actual, input pad_buttons_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL buttons got %h expected %h", actual, expected));
    end
  endtask

  task automatic check_present(input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL pad_present got %h expected %h", actual, expected));
    end
  endtask

  task automatic check_audio(input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL audio got %h expected %h", actual, expected));
    end
  endtask

  task automatic check_half_period(input tone_t actual, input tone_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL audio half period got %h expected %h", actual, expected));
    end
  endtask

  // One Pmod bit with data set first and the clock rising a hold later
  task automatic send_bit(input logic bit_val);
    repeat (HOLD) @(posedge clk);
    pmod_data <= bit_val;
    pmod_clk  <= 1'b0;
    repeat (HOLD) @(posedge clk);
    pmod_clk  <= 1'b1;
  endtask

  // Junk zeros first and then the frame from b down to r
  task automatic send_frame(input pad_frame_t frame_val, input int extra);
    for (int i = 0; i < extra; i++) begin
      send_bit(1'b0);
    end
    for (int i = PAD_BITS - 1; i >= 0; i--) begin
      send_bit(frame_val[i]);
    end
    repeat (HOLD) @(posedge clk);
    pmod_clk <= 1'b0;
  endtask

  task automatic latch_and_check(input pad_buttons_t exp_b, input logic exp_p);
    int waited;
    waited = 0;
    repeat (HOLD) @(posedge clk);
    pmod_latch <= 1'b1;
    // Outputs due by the third edge after the sampling edge
    do begin
      @(negedge clk);
      waited++;
    end while (!(buttons == exp_b && pad_present == exp_p) && waited < LATCH_TIMEOUT);
    if (!(buttons == exp_b && pad_present == exp_p)) begin
      $display("Timeout: pad outputs never followed the latch edge");
    end
    check_buttons(buttons, exp_b);
    check_present(pad_present, exp_p);
    @(posedge clk);
    pmod_latch <= 1'b0;
    repeat (HOLD) @(posedge clk);
    // Still held after latch drops
    check_buttons(buttons, exp_b);
    check_present(pad_present, exp_p);
  endtask

  // Sampled on falling edges and returns the cycle of the change
  task automatic wait_toggle(output int at_cycle);
    logic start_level;
    int   waited;
    start_level = audio;
    waited = 0;
    while (audio == start_level) begin
      @(negedge clk);
      waited++;
      if (waited > TOGGLE_TIMEOUT) begin
        abort_run("Timeout: audio output never toggled");
      end
    end
    at_cycle = cyc;
  endtask

  task automatic wait_for_cycle(input int target, input int pos);
    int waited;
    waited = 0;
    if (cyc > target) begin
      abort_run($sformatf("Melody position %0d window already passed", pos));
    end
    while (cyc < target) begin
      @(negedge clk);
      waited++;
      if (waited > WINDOW_TIMEOUT) begin
        abort_run($sformatf("Timeout: melody position %0d never reached", pos));
      end
    end
  endtask

  task automatic measure_note(input int pos, input int note_code);
    int    step;
    int    t_skip;
    int    t_start;
    int    t_end;
    tone_t expected;
    step = NOTE_TICKS + 1;
    if (note_code < 0 || note_code > 8) begin
      abort_run($sformatf("Note code %0d out of range in test file", note_code));
    end
    @(negedge clk);
    wait_for_cycle(pos * step + SETTLE, pos);
    // First toggle may come from a leftover count
    wait_toggle(t_skip);
    wait_toggle(t_start);
    wait_toggle(t_end);
    if (t_end >= (pos + 1) * step) begin
      abort_run($sformatf("Measurement for position %0d ran past its window", pos));
    end
    expected = tone_t'((TONE_REF[note_code] >> TONE_SHIFT) + 1);
    check_half_period(tone_t'(t_end - t_start), expected);
  endtask

  initial begin
    int         fd;
    int         n;
    string      line;
    pad_frame_t frame_val;
    pad_frame_t exp_b;
    int         exp_p;
    int         extra;
    int         pos;
    int         note_code;
    int         count_pad;
    int         count_mel;
    count_pad  = 0;
    count_mel  = 0;
    rst_n      = 1'b0;
    pmod_data  = 1'b1;
    pmod_clk   = 1'b0;
    pmod_latch = 1'b0;

    // Reset state seen before release
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_buttons(buttons, '0);
    check_present(pad_present, 1'b0);
    check_audio(audio, 1'b0);
    @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen("verif/spacewar_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open verif/spacewar_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      if (line[0] == "p") begin
        n = $sscanf(line.substr(4, line.len() - 1), "%h %h %d %d",
                    frame_val, exp_b, exp_p, extra);
        if (n != 4) begin
          abort_run({"Malformed pad line: ", line});
        end
        send_frame(frame_val, extra);
        latch_and_check(pad_buttons_t'(exp_b), exp_p[0]);
        count_pad++;
      end else if (line[0] == "m") begin
        n = $sscanf(line.substr(4, line.len() - 1), "%d %d", pos, note_code);
        if (n != 2) begin
          abort_run({"Malformed melody line: ", line});
        end
        measure_note(pos, note_code);
        count_mel++;
      end else begin
        abort_run({"Unknown line kind in test file: ", line});
      end
    end
    $fclose(fd);

    if (count_pad == 0 || count_mel == 0) begin
      abort_run("Test file held no pad lines or no melody lines");
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
